//--- sources.f
+incdir+verification
hw/nkmd_pkg.sv
hw/nkmd_fetch.sv
hw/nkmd_decode.sv
hw/nkmd_regfile.sv
hw/nkmd_operand.sv
hw/nkmd_execute.sv
hw/nkmd_writeback.sv
hw/nkmd_cpu.sv
verification/nkmd_cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= nkmd_cpu_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/nkmd_tb_model.svh
`ifndef NKMD_TB_MODEL_SVH
`define NKMD_TB_MODEL_SVH

function automatic logic [31:0] enc_alu(input logic [1:0] mw, input logic rr,
                                        input logic [3:0] rd, input logic [2:0] op,
                                        input logic [3:0] rs, input logic imm_en,
                                        input logic [15:0] imm);
    return {1'b0, mw, rr, rd, op, rs, imm_en, imm};
endfunction

// Register form with rt in bits 11:8 of the immediate field
function automatic logic [31:0] enc_rr(input logic [3:0] rd, input logic [2:0] op,
                                       input logic [3:0] rs, input logic [3:0] rt);
    return enc_alu(MW_REG, 1'b0, rd, op, rs, 1'b0, {4'b0, rt, 8'b0});
endfunction

// Link result is rs op r0 since the rt field stays zero
function automatic logic [31:0] enc_jmp(input logic [3:0] rd, input logic [3:0] rs,
                                        input logic [2:0] op, input logic [8:0] off);
    return {1'b1, 3'b0, rd, op, rs, 1'b0, off[8], 7'b0, off[7:0]};
endfunction

// Stores rs plus zero at the address held in r12
function automatic logic [31:0] enc_store(input logic [3:0] src);
    return enc_alu(MW_RBUS, 1'b0, 4'd12, OP_ADD, src, 1'b1, 16'h0000);
endfunction

function automatic logic [31:0] prog_word(input logic [31:0] addr);
    if ($isunknown(addr) || addr < RESET_PC || (addr - RESET_PC) >= 32'(prog.size())) begin
        return '0;
    end
    return prog[addr - RESET_PC];
endfunction

function automatic logic [31:0] here();
    return RESET_PC + 32'(prog.size());
endfunction

task automatic emit(input logic [31:0] w);
    prog.push_back(w);
endtask

task automatic nops(input int n);
    for (int i = 0; i < n; i++) begin
        emit(32'h0);
    end
endtask

task automatic li(input logic [3:0] rd, input logic [15:0] imm);
    emit(enc_alu(MW_REG, 1'b0, rd, OP_ADD, 4'd0, 1'b1, imm));
endtask

task automatic store_reg(input logic [3:0] src);
    li(4'd12, st_addr);
    st_addr = st_addr + 16'd1;
    nops(3);
    emit(enc_store(src));
    nops(3);
endtask

function automatic logic [31:0] ref_reg(input logic [3:0] sel);
    if (sel == 4'd0 || sel == 4'd11 || sel == 4'd15) begin
        return '0;
    end
    return ref_regs[sel];
endfunction

function automatic logic [31:0] ref_load(input logic [31:0] a);
    if (a < 32'(DMEM_DEPTH)) begin
        return ref_mem[a[7:0]];
    end
    return a ^ 32'ha5a5_5a5a;
endfunction

// Sequential execution with three delay slots after a jump
function automatic void run_reference();
    logic [31:0] pc, next, tgt, w, s, a, t, val, jt, imm, off;
    logic        jmp, rr, ie;
    logic [1:0]  mw;
    logic [3:0]  rd, rs, rt;
    logic [2:0]  op;
    int          pend;
    pc   = RESET_PC;
    tgt  = '0;
    pend = 0;
    for (int i = 0; i < 16; i++) begin
        ref_regs[i] = '0;
    end
    for (int step = 0; step < 20000; step++) begin
        w    = prog_word(pc);
        jmp  = w[31];
        mw   = jmp ? MW_REG : w[30:29];
        rr   = !jmp && w[28];
        ie   = !jmp && w[16];
        rd   = w[27:24];
        op   = w[23:21];
        rs   = w[20:17];
        rt   = w[11:8];
        imm  = {{16{w[15]}}, w[15:0]};
        off  = {{24{w[15]}}, w[7:0]};
        s    = ref_reg(rs);
        a    = ie ? imm : ref_reg(rt);
        t    = rr ? ref_load(a) : a;
        jt   = ref_reg(rd) + off;
        case (op)
            OP_ADD:  val = s + t;
            OP_SUB:  val = s - t;
            OP_OR:   val = s | t;
            OP_AND:  val = s & t;
            OP_XOR:  val = s ^ t;
            default: val = '0;
        endcase
        if (mw == MW_REG && !(rd inside {4'd0, 4'd11, 4'd15})) begin
            ref_regs[rd] = val;
        end else if (mw == MW_RBUS) begin
            exp_addr.push_back(ref_reg(rd));
            exp_data.push_back(val);
            if (ref_reg(rd) < 32'(DMEM_DEPTH)) begin
                ref_mem[ref_reg(rd) & 32'hff] = val;
            end
        end
        next = pc + 32'd1;
        if (pend > 0) begin
            pend--;
            if (pend == 0) begin
                next = tgt;
            end
        end
        if (jmp) begin
            // Self loop marks the end of the program
            if (jt == pc) begin
                return;
            end
            pend = 3;
            tgt  = jt;
        end
        pc = next;
    end
endfunction

`endif

//--- verification/nkmd_cpu_tb.sv
`timescale 1ns/1ps

module nkmd_cpu_tb import nkmd_pkg::*;;

    localparam logic [31:0] RESET_PC   = 32'd16;
    localparam int          DMEM_DEPTH = 256;
    localparam logic [31:0] SEED       = 32'hd0cc06ff;

    logic        clk;
    logic        rst;
    logic [31:0] p_data;
    logic [31:0] p_addr;
    logic [31:0] r_data;
    rbus_req_t   rbus_req;
    rbus_req_t   lat_req = '0;

    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] dmem      [DMEM_DEPTH];
    logic [31:0] dmem_init [DMEM_DEPTH];
    logic [31:0] ref_mem   [DMEM_DEPTH];
    logic [31:0] ref_regs  [16];
    logic [3:0]  t_sel     [3] = '{4'd0, 4'd11, 4'd15};
    logic [15:0] st_addr = 16'd200;
    int          limit;
    int          cycles;

    `include "nkmd_tb_model.svh"

    nkmd_cpu #(.RESET_PC(RESET_PC)) u_nkmd_cpu (
        .clk(clk), .rst(rst), .p_data_i(p_data), .p_addr_o(p_addr),
        .r_data_i(r_data), .rbus_req_o(rbus_req)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic build_program();
        logic [31:0] t;
        logic [31:0] lpc;
        logic [15:0] imm;
        // Word at the reset address is dropped by the decode clear
        nops(1);
        // Immediates of both signs
        for (int i = 0; i < 6; i++) begin
            imm     = 16'($urandom);
            imm[15] = i[0];
            li(4'd1, imm);
            nops(3);
            store_reg(4'd1);
        end
        // Register ALU ops and writes to the zero registers
        li(4'd1, 16'($urandom));
        li(4'd2, 16'($urandom));
        nops(3);
        for (int op = 0; op < 8; op++) begin
            emit(enc_rr(4'd3, 3'(op), 4'd1, 4'd2));
            nops(3);
            store_reg(4'd3);
        end
        foreach (t_sel[k]) begin
            emit(enc_rr(t_sel[k], OP_ADD, 4'd1, 4'd2));
            nops(3);
            store_reg(t_sel[k]);
        end
        // Loads from the low quarter of memory
        for (int k = 0; k < 2; k++) begin
            li(4'd3, 16'($urandom));
            nops(3);
            emit(enc_alu(MW_REG, 1'b1, 4'd4, OP_ADD, 4'd3, 1'b1, 16'($urandom_range(63, 0))));
            nops(3);
            store_reg(4'd4);
        end
        // Forward jump whose third slot stores and whose next three stores are skipped
        t = here() + 32'd12;
        li(4'd6, t[15:0]);
        li(4'd12, st_addr);
        st_addr = st_addr + 16'd1;
        nops(3);
        emit(enc_jmp(4'd6, 4'd6, OP_ADD, 9'd0));
        li(4'd7, 16'($urandom));
        nops(1);
        emit(enc_store(4'd1));
        emit(enc_store(4'd2));
        emit(enc_store(4'd2));
        emit(enc_store(4'd2));
        nops(3);
        store_reg(4'd7);
        // Backward loop with targets from a table at address 100
        li(4'd8, 16'd100);
        li(4'd14, 16'd1);
        li(4'd13, 16'd0);
        li(4'd12, st_addr);
        st_addr = st_addr + 16'd4;
        nops(3);
        lpc = here();
        emit(enc_alu(MW_REG, 1'b1, 4'd10, OP_ADD, 4'd0, 1'b0, {4'b0, 4'd8, 8'b0}));
        emit(enc_rr(4'd13, OP_ADD, 4'd13, 4'd14));
        nops(2);
        emit(enc_store(4'd13));
        emit(enc_rr(4'd8, OP_ADD, 4'd8, 4'd14));
        emit(enc_rr(4'd12, OP_ADD, 4'd12, 4'd14));
        emit(enc_jmp(4'd10, 4'd0, OP_ADD, 9'h1f8));
        nops(3);
        for (int k = 0; k < 4; k++) begin
            dmem_init[100 + k] = ((k < 3) ? lpc : here()) + 32'd8;
        end
        // Discarded results leave r5 alone
        li(4'd5, 16'($urandom));
        nops(3);
        emit(enc_alu(MW_DISCARD_T, 1'b0, 4'd5, OP_ADD, 4'd0, 1'b1, 16'h0077));
        emit(enc_alu(MW_DISCARD_C, 1'b0, 4'd5, OP_ADD, 4'd0, 1'b1, 16'h0078));
        nops(3);
        store_reg(4'd5);
        t = here() + 32'd4;
        li(4'd6, t[15:0]);
        nops(3);
        emit(enc_jmp(4'd6, 4'd6, OP_ADD, 9'd0));
        nops(3);
    endtask

    // Program memory answers the address of this cycle
    always @(posedge clk) begin
        #10;
        p_data = prog_word(p_addr);
    end

    always @(negedge clk) begin
        lat_req = rbus_req;
    end

    // Data memory with one cycle read latency
    always @(posedge clk) begin
        if (lat_req.we && lat_req.addr < 32'(DMEM_DEPTH)) begin
            dmem[lat_req.addr[7:0]] = lat_req.wdata;
        end
        #10;
        if (lat_req.addr < 32'(DMEM_DEPTH)) begin
            r_data = dmem[lat_req.addr[7:0]];
        end else begin
            r_data = lat_req.addr ^ 32'ha5a5_5a5a;
        end
    end

    always @(negedge clk) begin
        if (!rst && rbus_req.we) begin
            if (exp_addr.size() == 0) begin
                $display("Unexpected store to address %h with data %h at %0t",
                         rbus_req.addr, rbus_req.wdata, $time);
                $display("Testbench failed");
                $fatal(1, "extra store");
            end else begin
                check_value("store address", rbus_req.addr, exp_addr.pop_front());
                check_value("store data", rbus_req.wdata, exp_data.pop_front());
            end
        end
    end

    initial begin
        rst    = 1'b1;
        p_data = '0;
        r_data = '0;
        void'($urandom(SEED));
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem_init[i] = $urandom;
        end
        build_program();
        dmem    = dmem_init;
        ref_mem = dmem_init;
        run_reference();
        limit = 4 * prog.size() + 100;
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_value("p_addr in reset", p_addr, RESET_PC);
        @(posedge clk);
        #10;
        rst = 1'b0;
        cycles = 0;
        while (exp_addr.size() != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_addr.size() == 0) begin
            // Halt loop must stay quiet
            repeat (20) @(posedge clk);
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Cycle limit reached, %0d expected stores did not appear", exp_addr.size());
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

endmodule

//--- hw/nkmd_cpu.sv
`timescale 1ns/1ps

module nkmd_cpu import nkmd_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] p_data_i,
    output logic [XLEN-1:0] p_addr_o,
    input  logic [XLEN-1:0] r_data_i,
    output rbus_req_t       rbus_req_o
);

    inst_u               inst;
    dcd_ctrl_t           dcd_ctrl;
    logic [XLEN-1:0]     rs_val;
    logic [XLEN-1:0]     rt_val;
    logic [XLEN-1:0]     rd_val;
    logic [XLEN-1:0]     load_addr;
    opnd_t               opnd;
    ex_result_t          ex_result;
    jump_req_t           jump;
    logic [REGSEL_W-1:0] wr_sel;
    logic [XLEN-1:0]     wr_val;

    // Input side
    nkmd_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst(rst), .jump_i(jump),
        .p_data_i(p_data_i), .p_addr_o(p_addr_o), .inst_o(inst)
    );

    nkmd_decode u_decode (.clk(clk), .rst(rst), .inst_i(inst), .ctrl_o(dcd_ctrl));

    // Processing part
    nkmd_regfile u_regfile (
        .clk(clk), .rst(rst),
        .rs_sel_i(dcd_ctrl.rs), .rt_sel_i(dcd_ctrl.rt), .rd_sel_i(dcd_ctrl.rd),
        .rs_val_o(rs_val), .rt_val_o(rt_val), .rd_val_o(rd_val),
        .wr_sel_i(wr_sel), .wr_val_i(wr_val)
    );

    nkmd_operand u_operand (
        .clk(clk), .rst(rst), .ctrl_i(dcd_ctrl),
        .rs_val_i(rs_val), .rt_val_i(rt_val), .rd_val_i(rd_val),
        .r_data_i(r_data_i), .load_addr_o(load_addr), .opnd_o(opnd)
    );

    nkmd_execute u_execute (
        .clk(clk), .rst(rst), .opnd_i(opnd), .result_o(ex_result), .jump_o(jump)
    );

    // Output side
    nkmd_writeback u_writeback (
        .result_i(ex_result), .load_addr_i(load_addr),
        .wr_sel_o(wr_sel), .wr_val_o(wr_val), .rbus_req_o(rbus_req_o)
    );

    // A store never also updates a register
    a_store_no_regwrite: assert property (
        @(posedge clk) disable iff (rst)
        rbus_req_o.we |-> (wr_sel == REG_ZERO)
    );

endmodule

//--- hw/nkmd_writeback.sv
`timescale 1ns/1ps

module nkmd_writeback import nkmd_pkg::*; (
    input  ex_result_t          result_i,
    input  logic [XLEN-1:0]     load_addr_i,
    output logic [REGSEL_W-1:0] wr_sel_o,
    output logic [XLEN-1:0]     wr_val_o,
    output rbus_req_t           rbus_req_o
);

    logic store;

    always_comb begin
        wr_sel_o = REG_ZERO;
        store    = 1'b0;
        case (result_i.mw)
            MW_REG:  wr_sel_o = result_i.rd;
            MW_RBUS: store = 1'b1;
            // Result dropped
            MW_DISCARD_T, MW_DISCARD_C: ;
        endcase
    end

    assign wr_val_o = result_i.val;

    // Store wins the shared address, rd value is the store address
    always_comb begin
        rbus_req_o.addr  = store ? result_i.rd_val : load_addr_i;
        rbus_req_o.wdata = result_i.val;
        rbus_req_o.we    = store;
    end

endmodule

//--- hw/nkmd_execute.sv
`timescale 1ns/1ps

module nkmd_execute import nkmd_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  opnd_t      opnd_i,
    output ex_result_t result_o,
    output jump_req_t  jump_o
);

    logic [XLEN-1:0] alu_val;

    always_comb begin
        alu_val = '0;
        case (opnd_i.alu_op)
            OP_ADD:   alu_val = opnd_i.s_val + opnd_i.t_val;
            OP_SUB:   alu_val = opnd_i.s_val - opnd_i.t_val;
            OP_OR:    alu_val = opnd_i.s_val | opnd_i.t_val;
            OP_AND:   alu_val = opnd_i.s_val & opnd_i.t_val;
            OP_XOR:   alu_val = opnd_i.s_val ^ opnd_i.t_val;
            // Not implemented in this core
            OP_RESV, OP_CLAMP, OP_MUL: alu_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        result_o.val    <= alu_val;
        result_o.rd_val <= opnd_i.rd_val;
        // Target is relative to the rd value
        jump_o.target   <= opnd_i.rd_val + opnd_i.jmp_off;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_o.rd <= REG_ZERO;
            result_o.mw <= MW_REG;
            jump_o.en   <= 1'b0;
        end else begin
            result_o.rd <= opnd_i.rd;
            result_o.mw <= opnd_i.mw;
            jump_o.en   <= opnd_i.jmp_en;
        end
    end

endmodule

//--- hw/nkmd_operand.sv
`timescale 1ns/1ps

module nkmd_operand import nkmd_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  dcd_ctrl_t       ctrl_i,
    input  logic [XLEN-1:0] rs_val_i,
    input  logic [XLEN-1:0] rt_val_i,
    input  logic [XLEN-1:0] rd_val_i,
    input  logic [XLEN-1:0] r_data_i,
    output logic [XLEN-1:0] load_addr_o,
    output opnd_t           opnd_o
);

    logic [XLEN-1:0]     s_val_q;
    logic [XLEN-1:0]     addr_q;
    logic [XLEN-1:0]     rd_val_q;
    logic [XLEN-1:0]     jmp_off_q;
    logic                r_read_q;
    logic [REGSEL_W-1:0] rd_q;
    logic [ALUSEL_W-1:0] alu_op_q;
    logic [MWSEL_W-1:0]  mw_q;
    logic                jmp_en_q;

    // Presented to the R bus this cycle, data returns next cycle
    assign load_addr_o = ctrl_i.imm_en ? ctrl_i.imm : rt_val_i;

    always_ff @(posedge clk) begin
        s_val_q   <= rs_val_i;
        addr_q    <= load_addr_o;
        rd_val_q  <= rd_val_i;
        jmp_off_q <= ctrl_i.jmp_off;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_read_q <= 1'b0;
            rd_q     <= REG_ZERO;
            alu_op_q <= OP_ADD;
            mw_q     <= MW_REG;
            jmp_en_q <= 1'b0;
        end else begin
            r_read_q <= ctrl_i.r_read;
            rd_q     <= ctrl_i.rd;
            alu_op_q <= ctrl_i.alu_op;
            mw_q     <= ctrl_i.mw;
            jmp_en_q <= ctrl_i.jmp_en;
        end
    end

    // Without a bus read the address itself is the t operand
    always_comb begin
        opnd_o.s_val   = s_val_q;
        opnd_o.t_val   = r_read_q ? r_data_i : addr_q;
        opnd_o.rd      = rd_q;
        opnd_o.rd_val  = rd_val_q;
        opnd_o.alu_op  = alu_op_q;
        opnd_o.mw      = mw_q;
        opnd_o.jmp_en  = jmp_en_q;
        opnd_o.jmp_off = jmp_off_q;
    end

endmodule

//--- hw/nkmd_regfile.sv
`timescale 1ns/1ps

module nkmd_regfile import nkmd_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [REGSEL_W-1:0] rs_sel_i,
    input  logic [REGSEL_W-1:0] rt_sel_i,
    input  logic [REGSEL_W-1:0] rd_sel_i,
    output logic [XLEN-1:0]     rs_val_o,
    output logic [XLEN-1:0]     rt_val_o,
    output logic [XLEN-1:0]     rd_val_o,
    input  logic [REGSEL_W-1:0] wr_sel_i,
    input  logic [XLEN-1:0]     wr_val_i
);

    localparam int NREGS = 2 ** REGSEL_W;

    logic [XLEN-1:0] regs_q [NREGS];

    // zero, ra and pc hold no state here
    function automatic logic writable(input logic [REGSEL_W-1:0] sel);
        return !(sel inside {REG_ZERO, REG_RA, REG_PC});
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (writable(wr_sel_i)) begin
            regs_q[wr_sel_i] <= wr_val_i;
        end
    end

    assign rs_val_o = writable(rs_sel_i) ? regs_q[rs_sel_i] : '0;
    assign rt_val_o = writable(rt_sel_i) ? regs_q[rt_sel_i] : '0;
    assign rd_val_o = writable(rd_sel_i) ? regs_q[rd_sel_i] : '0;

    a_zero_reads: assert property (
        @(posedge clk) disable iff (rst)
        ((rs_sel_i == REG_ZERO) |-> (rs_val_o == '0)) and
        ((rt_sel_i == REG_ZERO) |-> (rt_val_o == '0)) and
        ((rd_sel_i == REG_ZERO) |-> (rd_val_o == '0))
    );

endmodule

//--- hw/nkmd_decode.sv
`timescale 1ns/1ps

module nkmd_decode import nkmd_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  inst_u     inst_i,
    output dcd_ctrl_t ctrl_o
);

    logic      rst_q;
    dcd_ctrl_t ctrl_d;

    always_comb begin
        ctrl_d        = '0;
        // Same bits in both views
        ctrl_d.rs     = inst_i.alu.rs;
        ctrl_d.rt     = inst_i.alu.rt;
        ctrl_d.rd     = inst_i.alu.rd;
        ctrl_d.alu_op = inst_i.alu.alu_op;
        if (inst_i.jmp.jump) begin
            ctrl_d.jmp_en = 1'b1;
            // Jump still writes its ALU result to rd
            ctrl_d.mw     = MW_REG;
        end else begin
            ctrl_d.r_read = inst_i.alu.r_read;
            ctrl_d.imm_en = inst_i.alu.imm_en;
            ctrl_d.mw     = inst_i.alu.mw;
        end
        // Both extend from bit 15
        ctrl_d.imm = {{(XLEN-15){inst_i.alu.sign}}, inst_i.alu.imm_hi,
                      inst_i.alu.rt, inst_i.alu.imm_lo};
        ctrl_d.jmp_off = {{(XLEN-8){inst_i.jmp.sign}}, inst_i.jmp.offset};
    end

    always_ff @(posedge clk) begin
        rst_q <= rst;
    end

    // Held at the no-op word one extra cycle after reset
    always_ff @(posedge clk) begin
        if (rst || rst_q) begin
            ctrl_o <= '0;
        end else begin
            ctrl_o <= ctrl_d;
        end
    end

    a_jump_flags: assert property (
        @(posedge clk) disable iff (rst)
        ctrl_o.jmp_en |-> !(ctrl_o.r_read || ctrl_o.imm_en)
    );

endmodule

//--- hw/nkmd_fetch.sv
`timescale 1ns/1ps

module nkmd_fetch import nkmd_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  jump_req_t       jump_i,
    input  logic [XLEN-1:0] p_data_i,
    output logic [XLEN-1:0] p_addr_o,
    output inst_u           inst_o
);

    logic [XLEN-1:0] pc_q;

    // Jump from execute overrides the sequential step
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (jump_i.en) begin
            pc_q <= jump_i.target;
        end else begin
            pc_q <= pc_q + XLEN'(1);
        end
    end

    assign p_addr_o = pc_q;

    // Program memory answers in the same cycle
    assign inst_o = p_data_i;

endmodule

//--- hw/nkmd_pkg.sv
package nkmd_pkg;

    localparam int XLEN     = 32;
    localparam int REGSEL_W = 4;
    localparam int ALUSEL_W = 3;
    localparam int MWSEL_W  = 2;

    // ALU op codes
    localparam logic [ALUSEL_W-1:0] OP_ADD   = 3'd0;
    localparam logic [ALUSEL_W-1:0] OP_SUB   = 3'd1;
    localparam logic [ALUSEL_W-1:0] OP_OR    = 3'd2;
    localparam logic [ALUSEL_W-1:0] OP_AND   = 3'd3;
    localparam logic [ALUSEL_W-1:0] OP_XOR   = 3'd4;
    localparam logic [ALUSEL_W-1:0] OP_RESV  = 3'd5;
    localparam logic [ALUSEL_W-1:0] OP_CLAMP = 3'd6;
    localparam logic [ALUSEL_W-1:0] OP_MUL   = 3'd7;

    // Writeback destination
    localparam logic [MWSEL_W-1:0] MW_REG       = 2'd0;
    localparam logic [MWSEL_W-1:0] MW_RBUS      = 2'd1;
    localparam logic [MWSEL_W-1:0] MW_DISCARD_T = 2'd2;
    localparam logic [MWSEL_W-1:0] MW_DISCARD_C = 2'd3;

    // Selectors that always read zero
    localparam logic [REGSEL_W-1:0] REG_ZERO = 4'd0;
    localparam logic [REGSEL_W-1:0] REG_RA   = 4'd11;
    localparam logic [REGSEL_W-1:0] REG_PC   = 4'd15;

    // Register/immediate form, rt sits inside the immediate
    typedef struct packed {
        logic                jump;
        logic [MWSEL_W-1:0]  mw;
        logic                r_read;
        logic [REGSEL_W-1:0] rd;
        logic [ALUSEL_W-1:0] alu_op;
        logic [REGSEL_W-1:0] rs;
        logic                imm_en;
        logic                sign;
        logic [2:0]          imm_hi;
        logic [REGSEL_W-1:0] rt;
        logic [7:0]          imm_lo;
    } inst_alu_t;

    typedef struct packed {
        logic                jump;
        logic [2:0]          rsvd_hi;
        logic [REGSEL_W-1:0] rd;
        logic [ALUSEL_W-1:0] alu_op;
        logic [REGSEL_W-1:0] rs;
        logic                rsvd_mid;
        logic                sign;
        logic [6:0]          rsvd_lo;
        logic [7:0]          offset;
    } inst_jmp_t;

    typedef union packed {
        inst_alu_t alu;
        inst_jmp_t jmp;
    } inst_u;

    typedef struct packed {
        logic [REGSEL_W-1:0] rs;
        logic [REGSEL_W-1:0] rt;
        logic [REGSEL_W-1:0] rd;
        logic [ALUSEL_W-1:0] alu_op;
        logic [XLEN-1:0]     imm;
        logic [XLEN-1:0]     jmp_off;
        logic                r_read;
        logic                imm_en;
        logic                jmp_en;
        logic [MWSEL_W-1:0]  mw;
    } dcd_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]     s_val;
        logic [XLEN-1:0]     t_val;
        logic [REGSEL_W-1:0] rd;
        logic [XLEN-1:0]     rd_val;
        logic [ALUSEL_W-1:0] alu_op;
        logic [MWSEL_W-1:0]  mw;
        logic                jmp_en;
        logic [XLEN-1:0]     jmp_off;
    } opnd_t;

    typedef struct packed {
        logic [XLEN-1:0]     val;
        logic [REGSEL_W-1:0] rd;
        logic [XLEN-1:0]     rd_val;
        logic [MWSEL_W-1:0]  mw;
    } ex_result_t;

    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] target;
    } jump_req_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            we;
    } rbus_req_t;

endpackage
